// File: verilog/agc_settings.svh
// word and address widths
// erasable size, fixed-memory base and reset address
// addresses of the mapped registers
`ifndef AGC_SETTINGS_SVH
`define AGC_SETTINGS_SVH

// stored word carries overflow in bit 15
`define AGC_WORD_BITS 16
`define AGC_ADDR_BITS 12

// only the bottom of erasable is built
`define AGC_ERASABLE_WORDS 64

// fixed memory starts here, and so does execution
`define AGC_FIXED_BASE 12'o2000
`define AGC_RESET_Z 12'o2000

// registers mapped into erasable
`define AGC_ADDR_A 12'd0
`define AGC_ADDR_L 12'd1
`define AGC_ADDR_Q 12'd2
`define AGC_ADDR_Z 12'd5

`endif

// File: verilog/agc_isa_pkg.sv
// instruction-set types
// stored word, address, two-way instruction decode and operation class
`include "agc_settings.svh"

package agc_isa_pkg;

  // bit 15 overflow, bit 14 sign, bits 13..0 magnitude
  typedef logic [`AGC_WORD_BITS-1:0] agc_word_t;

  typedef logic [`AGC_ADDR_BITS-1:0] agc_addr_t;

  // one instruction word, seen two ways
  typedef union packed {
    // opcode with a full 12-bit address
    struct packed {
      logic       spare;
      logic [2:0] opcode;
      agc_addr_t  addr;
    } basic;
    // opcode, quarter code and an erasable address
    struct packed {
      logic       spare;
      logic [2:0] opcode;
      logic [1:0] qc;
      logic [9:0] eaddr;
    } quarter;
  } agc_instr_u;

  typedef enum logic [3:0] {
    op_nop,
    op_tc,
    op_tcf,
    op_ca,
    op_cs,
    op_ad,
    op_mask,
    op_ts,
    op_xch,
    op_incr
  } agc_op_e;

endpackage

// File: verilog/agc_bus_pkg.sv
// structs passed between the pipeline stages
// decoded operation, erasable write request, fixed-memory read request

package agc_bus_pkg;
  import agc_isa_pkg::*;

  // decode result handed to execute
  typedef struct packed {
    agc_op_e   op;
    agc_addr_t addr;
  } agc_decoded_t;

  // one word written into erasable
  typedef struct packed {
    logic      enable;
    agc_addr_t addr;
    agc_word_t data;
  } agc_write_t;

  // fixed-memory read, answered one cycle later
  typedef struct packed {
    logic      enable;
    agc_addr_t addr;
  } agc_fixed_req_t;

endpackage

// File: verilog/agc_fetch.sv
// instruction fetch stage
// owns the fixed-memory port, shared by fetches and operand reads
`timescale 1ns/1ns

module agc_fetch
  import agc_isa_pkg::*, agc_bus_pkg::*;
(
  input  logic           raw_clk,
  input  logic           button_reset,
  input  logic           fetch_start,
  input  agc_fixed_req_t operand_req,
  input  agc_addr_t      reg_z,
  input  agc_word_t      rom_data,
  output agc_fixed_req_t rom_req,
  output logic           instr_valid,
  output agc_instr_u     instr_word,
  output logic           z_increment,
  output logic           operand_valid,
  output agc_word_t      operand_data
);

  logic           first_q;
  logic           start;
  agc_fixed_req_t req_q;
  logic           req_is_operand_q;
  logic           fetch_done_q;
  logic           operand_done_q;

  // kick off the first fetch right after reset
  assign start = fetch_start | first_q;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      first_q          <= 1'b1;
      req_q            <= '0;
      req_is_operand_q <= 1'b0;
      fetch_done_q     <= 1'b0;
      operand_done_q   <= 1'b0;
    end
    else
    begin
      first_q        <= 1'b0;
      fetch_done_q   <= req_q.enable & ~req_is_operand_q;
      operand_done_q <= req_q.enable & req_is_operand_q;
      if (start)
      begin
        req_q            <= '{enable: 1'b1, addr: reg_z};
        req_is_operand_q <= 1'b0;
      end
      else if (operand_req.enable)
      begin
        req_q            <= operand_req;
        req_is_operand_q <= 1'b1;
      end
      else
        req_q.enable <= 1'b0;
    end
  end

  assign rom_req = req_q;

  // returned word goes to whoever asked
  assign instr_valid   = fetch_done_q;
  assign z_increment   = fetch_done_q;
  assign instr_word    = rom_data;
  assign operand_valid = operand_done_q;
  assign operand_data  = rom_data;

  // execute only asks for an operand while no fetch is due
  a_no_port_clash: assert property (@(posedge raw_clk) disable iff (!button_reset)
    !(fetch_start && operand_req.enable));

endmodule

// File: verilog/agc_decode.sv
// decode stage
// classifies an instruction word and picks its effective address
`timescale 1ns/1ns

module agc_decode
  import agc_isa_pkg::*, agc_bus_pkg::*;
(
  input  logic         raw_clk,
  input  logic         button_reset,
  input  logic         instr_valid,
  input  agc_instr_u   instr_word,
  output logic         op_valid,
  output agc_decoded_t op
);

  agc_op_e   op_class;
  agc_addr_t eff_addr;
  logic      short_addr;

  always_comb
  begin
    unique case (instr_word.basic.opcode)
      3'd0: op_class = op_tc;
      // quarter code zero is CCS, not kept
      3'd1: op_class = (instr_word.quarter.qc != 2'd0) ? op_tcf : op_nop;
      3'd2: op_class = (instr_word.quarter.qc == 2'd2) ? op_incr : op_nop;
      3'd3: op_class = op_ca;
      3'd4: op_class = op_cs;
      3'd5:
      begin
        case (instr_word.quarter.qc)
          2'd2:    op_class = op_ts;
          2'd3:    op_class = op_xch;
          default: op_class = op_nop;
        endcase
      end
      3'd6: op_class = op_ad;
      3'd7: op_class = op_mask;
      default: op_class = op_nop;
    endcase
  end

  // erasable-only instructions carry a 10-bit address
  assign short_addr = (op_class == op_ts) || (op_class == op_xch) || (op_class == op_incr);

  always_comb
  begin
    if (short_addr)
      eff_addr = agc_addr_t'(instr_word.quarter.eaddr);
    else
      eff_addr = instr_word.basic.addr;
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
      op_valid <= 1'b0;
    else
      op_valid <= instr_valid;
  end

  // held until the next instruction arrives
  always_ff @(posedge raw_clk)
  begin
    if (instr_valid)
    begin
      op.op   <= op_class;
      op.addr <= eff_addr;
    end
  end

endmodule

// File: verilog/agc_execute.sv
// execute stage
// operand read, one's-complement ALU and write sequencing per instruction
`timescale 1ns/1ns
`include "agc_settings.svh"

module agc_execute
  import agc_isa_pkg::*, agc_bus_pkg::*;
(
  input  logic           raw_clk,
  input  logic           button_reset,
  input  logic           op_valid,
  input  agc_decoded_t   op,
  input  logic           operand_valid,
  input  agc_word_t      operand_data,
  input  agc_word_t      read_data,
  input  agc_word_t      reg_a,
  input  agc_addr_t      reg_z,
  output agc_fixed_req_t operand_req,
  output agc_addr_t      read_addr,
  output agc_write_t     wr,
  output logic           fetch_start
);

  typedef enum logic [2:0] {
    st_idle,
    st_issue,
    st_opwait,
    st_write1,
    st_write2,
    st_done
  } exec_state_e;

  exec_state_e  state;
  agc_decoded_t op_q;
  agc_word_t    operand_q;
  agc_word_t    result;
  logic [15:0]  sum;
  logic [14:0]  sum_wrapped;
  logic         needs_operand;
  logic         is_fixed;

  function automatic agc_write_t make_write(input agc_addr_t addr, input agc_word_t data);
    agc_write_t w;
    w.enable = 1'b1;
    w.addr   = addr;
    w.data   = data;
    return w;
  endfunction

  assign needs_operand = op_q.op inside {op_ca, op_cs, op_ad, op_mask, op_xch, op_incr};
  assign is_fixed      = op_q.addr >= `AGC_FIXED_BASE;
  assign read_addr     = op_q.addr;

  // one's-complement add with end-around carry
  assign sum         = {1'b0, reg_a[14:0]} + {1'b0, operand_q[14:0]};
  assign sum_wrapped = sum[14:0] + 15'(sum[15]);

  always_comb
  begin
    case (op_q.op)
      op_cs:   result = {1'b0, ~operand_q[14:0]};
      op_ad:   result = {(reg_a[14] == operand_q[14]) && (sum_wrapped[14] != operand_q[14]),
                         sum_wrapped};
      op_mask: result = {1'b0, operand_q[14:0] & reg_a[14:0]};
      op_incr: result = operand_q + 1'b1;
      default: result = operand_q;
    endcase
  end

  always_comb
  begin
    operand_req = '0;
    wr          = '0;
    fetch_start = 1'b0;
    case (state)
      st_issue:
        if (needs_operand && is_fixed)
          operand_req = '{enable: 1'b1, addr: op_q.addr};
      st_write1:
      begin
        case (op_q.op)
          // Z already points past the TC, so it is the return address
          op_tc:                          wr = make_write(`AGC_ADDR_Q, agc_word_t'(reg_z));
          op_tcf:                         wr = make_write(`AGC_ADDR_Z, agc_word_t'(op_q.addr));
          op_ca, op_cs, op_ad, op_mask:   wr = make_write(`AGC_ADDR_A, result);
          op_ts, op_xch:                  wr = make_write(op_q.addr, reg_a);
          op_incr:                        wr = make_write(op_q.addr, result);
          default:                        wr = '0;
        endcase
      end
      st_write2:
      begin
        if (op_q.op == op_tc)
          wr = make_write(`AGC_ADDR_Z, agc_word_t'(op_q.addr));
        else
          wr = make_write(`AGC_ADDR_A, operand_q);
      end
      st_done: fetch_start = 1'b1;
      default: fetch_start = 1'b0;
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
      state <= st_idle;
    else
    begin
      case (state)
        st_idle:   if (op_valid) state <= st_issue;
        st_issue:  state <= (needs_operand && is_fixed) ? st_opwait : st_write1;
        st_opwait: if (operand_valid) state <= st_write1;
        st_write1: state <= (op_q.op inside {op_tc, op_xch}) ? st_write2 : st_done;
        st_write2: state <= st_done;
        default:   state <= st_idle;
      endcase
    end
  end

  // erasable operands are latched before the first write can change them
  always_ff @(posedge raw_clk)
  begin
    if (state == st_idle && op_valid)
      op_q <= op;
    if (state == st_issue)
      operand_q <= read_data;
    else if (state == st_opwait && operand_valid)
      operand_q <= operand_data;
  end

  // writes settle before fetch samples Z
  a_write_before_fetch: assert property (@(posedge raw_clk) disable iff (!button_reset)
    wr.enable |-> !fetch_start);

endmodule

// File: verilog/agc_erasable.sv
// erasable memory
// mapped A, L, Q and Z, with Z advanced after each fetch
`timescale 1ns/1ns
`include "agc_settings.svh"

module agc_erasable
  import agc_isa_pkg::*, agc_bus_pkg::*;
#(
  parameter int words = `AGC_ERASABLE_WORDS
)
(
  input  logic       raw_clk,
  input  logic       button_reset,
  input  agc_write_t wr,
  input  logic       z_increment,
  input  agc_addr_t  read_addr,
  output agc_word_t  read_data,
  output agc_word_t  reg_a,
  output agc_addr_t  reg_z
);

  localparam int idx_bits = $clog2(words);
  localparam logic [idx_bits-1:0] a_slot = idx_bits'(`AGC_ADDR_A);

  agc_word_t mem [words];
  agc_addr_t z_q;
  logic      rd_hit;
  logic      wr_hit;

  // anything past the built words reads zero
  assign rd_hit = read_addr < words;
  assign wr_hit = wr.addr < words;

  always_comb
  begin
    if (read_addr == `AGC_ADDR_Z)
      read_data = agc_word_t'(z_q);
    else if (rd_hit)
      read_data = mem[read_addr[idx_bits-1:0]];
    else
      read_data = '0;
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      for (int i = 0; i < words; i++)
        mem[i] <= '0;
      z_q <= `AGC_RESET_Z;
    end
    else if (wr.enable)
    begin
      // Z lives in its own 12-bit register
      if (wr.addr == `AGC_ADDR_Z)
        z_q <= wr.data[`AGC_ADDR_BITS-1:0];
      else if (wr_hit)
        mem[wr.addr[idx_bits-1:0]] <= wr.data;
    end
    else if (z_increment)
      z_q <= z_q + 1'b1;
  end

  assign reg_a = mem[a_slot];
  assign reg_z = z_q;

  // Z stepping and execute writes belong to different phases of an instruction
  a_no_write_on_step: assert property (@(posedge raw_clk) disable iff (!button_reset)
    !(wr.enable && z_increment));

endmodule

// File: verilog/agc_core.sv
// top level of the core
// fetch, decode and execute around the erasable memory
`timescale 1ns/1ns

module agc_core
  import agc_isa_pkg::*, agc_bus_pkg::*;
(
  input  logic           raw_clk,
  input  logic           button_reset,
  input  agc_word_t      rom_data,
  output agc_fixed_req_t rom_req,
  output agc_word_t      reg_a,
  output agc_addr_t      reg_z
);

  logic           fetch_start;
  agc_fixed_req_t operand_req;
  logic           instr_valid;
  agc_instr_u     instr_word;
  logic           z_increment;
  logic           operand_valid;
  agc_word_t      operand_data;
  logic           op_valid;
  agc_decoded_t   op;
  agc_write_t     wr;
  agc_addr_t      read_addr;
  agc_word_t      read_data;

  agc_fetch u_fetch (
    .raw_clk       (raw_clk),
    .button_reset  (button_reset),
    .fetch_start   (fetch_start),
    .operand_req   (operand_req),
    .reg_z         (reg_z),
    .rom_data      (rom_data),
    .rom_req       (rom_req),
    .instr_valid   (instr_valid),
    .instr_word    (instr_word),
    .z_increment   (z_increment),
    .operand_valid (operand_valid),
    .operand_data  (operand_data)
  );

  agc_decode u_decode (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .instr_valid  (instr_valid),
    .instr_word   (instr_word),
    .op_valid     (op_valid),
    .op           (op)
  );

  agc_execute u_execute (
    .raw_clk       (raw_clk),
    .button_reset  (button_reset),
    .op_valid      (op_valid),
    .op            (op),
    .operand_valid (operand_valid),
    .operand_data  (operand_data),
    .read_data     (read_data),
    .reg_a         (reg_a),
    .reg_z         (reg_z),
    .operand_req   (operand_req),
    .read_addr     (read_addr),
    .wr            (wr),
    .fetch_start   (fetch_start)
  );

  agc_erasable u_erasable (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .wr           (wr),
    .z_increment  (z_increment),
    .read_addr    (read_addr),
    .read_data    (read_data),
    .reg_a        (reg_a),
    .reg_z        (reg_z)
  );

endmodule

// File: tests/agc_core_tb.sv
// testbench for the core
// random fixed-memory program, fixed-memory responder and reference model
`timescale 1ns/1ns
`include "agc_settings.svh"

module agc_core_tb
  import agc_isa_pkg::*, agc_bus_pkg::*;
();

  localparam int num_instr        = 2000;
  localparam int reset_cycles     = 8;
  localparam int cycles_per_instr = 40;
  localparam int cycle_limit      = (num_instr + 1) * cycles_per_instr + reset_cycles;
  localparam int fixed_words      = 1024;
  localparam int erasable_words   = `AGC_ERASABLE_WORDS;

  logic           raw_clk;
  logic           button_reset;
  agc_word_t      rom_data;
  agc_fixed_req_t rom_req;
  agc_word_t      reg_a;
  agc_addr_t      reg_z;

  agc_word_t      fixed_mem [fixed_words];
  agc_fixed_req_t pending_req;
  logic [31:0]    rng;
  int             cycle_count;
  int             executed;

  // reference model
  agc_word_t      model_mem [erasable_words];
  agc_addr_t      model_z;
  logic           operand_pending;
  agc_addr_t      pending_operand_addr;

  agc_core dut (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .rom_data     (rom_data),
    .rom_req      (rom_req),
    .reg_a        (reg_a),
    .reg_z        (reg_z)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function int draw(input int range);
    rng = xorshift(rng);
    return int'(rng % 32'(range));
  endfunction

  function agc_addr_t pick_erasable();
    int a;
    a = draw(erasable_words);
    // Z is never an operand
    if (a == int'(`AGC_ADDR_Z))
      a = a + 1;
    return agc_addr_t'(a);
  endfunction

  function agc_addr_t pick_fixed();
    return agc_addr_t'(int'(`AGC_FIXED_BASE) + draw(fixed_words));
  endfunction

  function agc_word_t basic_word(input logic [2:0] opc, input agc_addr_t addr);
    return {1'b0, opc, addr};
  endfunction

  function agc_word_t quarter_word(input logic [2:0] opc, input logic [1:0] qc,
                                   input logic [9:0] eaddr);
    return {1'b0, opc, qc, eaddr};
  endfunction

  // codes the core leaves out such as CCS, DAS, LXCH and INDEX
  function agc_word_t unsupported_word();
    int         pick;
    logic [9:0] field;
    agc_word_t  w;
    pick  = draw(6);
    field = 10'(draw(1024));
    case (pick)
      0:       w = quarter_word(3'd1, 2'd0, field);
      1:       w = quarter_word(3'd2, 2'd0, field);
      2:       w = quarter_word(3'd2, 2'd1, field);
      3:       w = quarter_word(3'd2, 2'd3, field);
      4:       w = quarter_word(3'd5, 2'd0, field);
      default: w = quarter_word(3'd5, 2'd1, field);
    endcase
    return w;
  endfunction

  function agc_word_t random_instr();
    int        kind;
    agc_addr_t ea;
    agc_addr_t load_addr;
    agc_word_t w;
    kind = draw(12);
    ea   = pick_erasable();
    // loads read erasable or fixed about equally
    load_addr = (draw(2) == 0) ? ea : pick_fixed();
    case (kind)
      0:       w = basic_word(3'd0, pick_fixed());
      1:       w = basic_word(3'd1, pick_fixed());
      2, 10:   w = basic_word(3'd3, load_addr);
      3:       w = basic_word(3'd4, load_addr);
      4, 11:   w = basic_word(3'd6, load_addr);
      5:       w = basic_word(3'd7, load_addr);
      6:       w = quarter_word(3'd5, 2'd2, ea[9:0]);
      7:       w = quarter_word(3'd5, 2'd3, ea[9:0]);
      8:       w = quarter_word(3'd2, 2'd2, ea[9:0]);
      default: w = unsupported_word();
    endcase
    return w;
  endfunction

  task fill_program();
    for (int i = 0; i < fixed_words - 1; i++)
      fixed_mem[i] = random_instr();
    // last word jumps back so Z stays inside fixed memory
    fixed_mem[fixed_words - 1] = basic_word(3'd1, `AGC_FIXED_BASE);
  endtask

  function int fixed_index(input agc_addr_t addr);
    return int'(addr) - int'(`AGC_FIXED_BASE);
  endfunction

  function logic in_fixed(input agc_addr_t addr);
    return (fixed_index(addr) >= 0) && (fixed_index(addr) < fixed_words);
  endfunction

  task abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s, got %0o expected %0o", $time, what, got, exp);
      abort_run();
    end
  endtask

  function agc_word_t read_model(input agc_addr_t addr);
    if (addr == `AGC_ADDR_Z)
      return agc_word_t'(model_z);
    else if (int'(addr) < erasable_words)
      return model_mem[addr];
    else
      return '0;
  endfunction

  task write_model(input agc_addr_t addr, input agc_word_t data);
    if (addr == `AGC_ADDR_Z)
      model_z = data[11:0];
    else if (int'(addr) < erasable_words)
      model_mem[addr] = data;
  endtask

  // fixed operands also mean one more rom_req before the next fetch
  task load_operand(input agc_addr_t addr, output agc_word_t value);
    if (addr >= `AGC_FIXED_BASE)
    begin
      operand_pending      = 1'b1;
      pending_operand_addr = addr;
      value                = fixed_mem[fixed_index(addr)];
    end
    else
      value = read_model(addr);
  endtask

  // one's-complement add over 15 bits with overflow in bit 15
  function agc_word_t ones_add(input agc_word_t a, input agc_word_t b);
    int          total;
    logic [14:0] folded;
    logic        ovf;
    total = int'(a[14:0]) + int'(b[14:0]);
    // a carry out of bit 14 comes back in at bit 0
    if (total > 32'h7fff)
      total = total - 32'h7fff;
    folded = total[14:0];
    ovf    = (a[14] == b[14]) && (folded[14] != a[14]);
    return {ovf, folded};
  endfunction

  task step_model();
    agc_word_t  iw;
    logic [2:0] opc;
    logic [1:0] qc;
    agc_addr_t  addr12;
    agc_addr_t  addr10;
    agc_word_t  operand;
    agc_word_t  a;
    iw     = fixed_mem[fixed_index(model_z)];
    opc    = iw[14:12];
    qc     = iw[11:10];
    addr12 = iw[11:0];
    addr10 = {2'b00, iw[9:0]};
    a      = model_mem[`AGC_ADDR_A];
    // Z moves past the instruction before it runs
    model_z = model_z + 12'd1;
    case (opc)
      3'd0:
      begin
        write_model(`AGC_ADDR_Q, agc_word_t'(model_z));
        model_z = addr12;
      end
      3'd1:
      begin
        if (qc != 2'd0)
          model_z = addr12;
      end
      3'd2:
      begin
        if (qc == 2'd2)
          write_model(addr10, read_model(addr10) + 16'd1);
      end
      3'd5:
      begin
        if (qc == 2'd2)
          write_model(addr10, a);
        else if (qc == 2'd3)
        begin
          operand = read_model(addr10);
          write_model(addr10, a);
          write_model(`AGC_ADDR_A, operand);
        end
      end
      default:
      begin
        load_operand(addr12, operand);
        case (opc)
          3'd3:    write_model(`AGC_ADDR_A, operand);
          3'd4:    write_model(`AGC_ADDR_A, {1'b0, ~operand[14:0]});
          3'd6:    write_model(`AGC_ADDR_A, ones_add(a, operand));
          default: write_model(`AGC_ADDR_A, {1'b0, operand[14:0] & a[14:0]});
        endcase
      end
    endcase
  endtask

  // the previous instruction has fully retired when its successor is fetched
  task handle_fetch();
    check_value(32'(rom_req.addr), 32'(model_z), "fetch address");
    check_value(32'(reg_z), 32'(model_z), "reg_z at fetch");
    check_value(32'(reg_a), 32'(model_mem[`AGC_ADDR_A]), "reg_a at fetch");
    if (executed == num_instr)
    begin
      $display("%0d instructions checked in %0d cycles", executed, cycle_count);
      $display("Test passed");
      $finish;
    end
    else
    begin
      step_model();
      executed = executed + 1;
    end
  endtask

  initial
  begin
    raw_clk = 1'b0;
    forever #50 raw_clk = ~raw_clk;
  end

  initial
  begin
    button_reset    = 1'b0;
    rom_data        = '0;
    pending_req     = '0;
    rng             = 32'he9e0_8fda;
    cycle_count     = 0;
    executed        = 0;
    operand_pending = 1'b0;
    model_z         = `AGC_RESET_Z;
    for (int i = 0; i < erasable_words; i++)
      model_mem[i] = '0;
    fill_program();
    repeat (reset_cycles) @(negedge raw_clk);
    check_value(32'(rom_req.enable), 32'd0, "rom_req enable during reset");
    button_reset = 1'b1;
    @(negedge raw_clk);
    check_value(32'(rom_req.enable), 32'd1, "first fetch one cycle after reset");
    check_value(32'(rom_req.addr), 32'(`AGC_RESET_Z), "first fetch address");
    check_value(32'(reg_a), 32'd0, "reg_a after reset");
  end

  // fixed-memory responder and request checker
  always @(negedge raw_clk)
  begin
    if (pending_req.enable)
      rom_data <= fixed_mem[fixed_index(pending_req.addr)];
    else
      rom_data <= agc_word_t'(draw(65536));
    pending_req <= rom_req;
    if (rom_req.enable)
    begin
      if (!in_fixed(rom_req.addr))
      begin
        $display("fixed-memory request at %0t to address %0o is outside the program",
                 $time, rom_req.addr);
        abort_run();
      end
      else if (operand_pending)
      begin
        check_value(32'(rom_req.addr), 32'(pending_operand_addr), "operand read address");
        operand_pending = 1'b0;
      end
      else
        handle_fetch();
    end
  end

  always @(posedge raw_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("run timed out after %0d cycles with %0d of %0d instructions checked",
               cycle_count, executed, num_instr);
      abort_run();
    end
  end

endmodule

// File: agc_core.f
+incdir+verilog
verilog/agc_isa_pkg.sv
verilog/agc_bus_pkg.sv
verilog/agc_fetch.sv
verilog/agc_decode.sv
verilog/agc_execute.sv
verilog/agc_erasable.sv
verilog/agc_core.sv
tests/agc_core_tb.sv

// File: Makefile
# Verilator build and run for the AGC core testbench
# override any variable on the command line, e.g. make sim TOP=agc_core_tb

VERILATOR ?= verilator
TOP       ?= agc_core_tb
FILELIST  ?= agc_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# build, then run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
